//--- hw/eva_npa_pkg.sv
// eva to npa translation package
// mesh geometry, eva field positions per address class
// and the address-class enum shared by the translator blocks

package eva_npa_pkg;

  // address and coordinate widths
  localparam int eva_width_c      = 32;
  localparam int pod_cord_width_c = 3;
  localparam int x_sub_width_c    = 4;
  localparam int y_sub_width_c    = 4;
  localparam int x_cord_width_c   = pod_cord_width_c + x_sub_width_c;
  localparam int y_cord_width_c   = pod_cord_width_c + y_sub_width_c;
  // word address inside an endpoint
  localparam int epa_width_c      = 16;

  // tiles per pod
  localparam int num_tiles_x_c        = 16;
  localparam int num_tiles_y_c        = 8;
  localparam int vcache_block_words_c = 8;

  // vcache rows frame the tile array, tiles sit on rows 1..8
  localparam logic [y_sub_width_c-1:0] north_vcache_sub_c = 4'd0;
  localparam logic [y_sub_width_c-1:0] south_vcache_sub_c = y_sub_width_c'(num_tiles_y_c + 1);

  // keeps tile-group accesses inside dmem
  localparam logic [epa_width_c-1:0] tg_epa_mask_c = 16'h03FF;

  // class tags in the top eva bits
  localparam int         dram_tag_bit_c = 31;
  localparam logic [1:0] glb_tag_c      = 2'b01;
  localparam logic [2:0] tg_tag_c       = 3'b001;
  localparam logic [2:0] inv_tag_c      = 3'b000;

  // dram fields
  localparam int dram_word_lsb_c = 2;
  localparam int dram_word_msb_c = 4;
  localparam int dram_col_lsb_c  = 5;
  localparam int dram_col_msb_c  = 8;
  localparam int dram_ns_bit_c   = 9;
  localparam int dram_blk_lsb_c  = 10;
  localparam int dram_blk_msb_c  = 30;

  // global fields
  localparam int glb_y_msb_c    = 29;
  localparam int glb_y_lsb_c    = 24;
  localparam int glb_x_msb_c    = 23;
  localparam int glb_x_lsb_c    = 18;
  localparam int glb_word_msb_c = 17;
  localparam int glb_word_lsb_c = 2;

  // tile-group fields
  localparam int tg_y_msb_c    = 27;
  localparam int tg_y_lsb_c    = 25;
  localparam int tg_x_msb_c    = 24;
  localparam int tg_x_lsb_c    = 21;
  localparam int tg_word_msb_c = 17;
  localparam int tg_word_lsb_c = 2;

  // address class of a translated eva
  typedef enum logic [1:0] {
    ADDR_DRAM       = 2'd0,
    ADDR_GLOBAL     = 2'd1,
    ADDR_TILE_GROUP = 2'd2,
    ADDR_INVALID    = 2'd3
  } addr_kind_e;

endpackage

//--- hw/dram_hash.sv
// dram hash
// stripes the dram eva space over the vcaches of one pod,
// one cache block per vcache before moving to the next column,
// north row first, then the south row

module dram_hash (
  input  logic [eva_npa_pkg::eva_width_c-1:0]      eva_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_x_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_y_i,
  output logic [eva_npa_pkg::x_cord_width_c-1:0]   x_cord_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0]   y_cord_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]      epa_o
);

  import eva_npa_pkg::*;

  // field widths
  localparam int word_w_lp = dram_word_msb_c - dram_word_lsb_c + 1;
  localparam int col_w_lp  = dram_col_msb_c - dram_col_lsb_c + 1;
  localparam int blk_w_lp  = dram_blk_msb_c - dram_blk_lsb_c + 1;

  // word inside the cache block
  logic [word_w_lp-1:0]     word_in_blk;
  // vcache column inside the pod
  logic [col_w_lp-1:0]      vcache_col;
  // 0 north row, 1 south row
  logic                     south_sel;
  // block number inside the selected vcache
  logic [blk_w_lp-1:0]      blk_idx;
  logic [y_sub_width_c-1:0] vcache_row_sub;

  assign word_in_blk = eva_i[dram_word_msb_c:dram_word_lsb_c];
  assign vcache_col  = eva_i[dram_col_msb_c:dram_col_lsb_c];
  assign south_sel   = eva_i[dram_ns_bit_c];
  assign blk_idx     = eva_i[dram_blk_msb_c:dram_blk_lsb_c];

  // row subcord of the target vcache
  always_comb begin
    if (south_sel) begin
      vcache_row_sub = south_vcache_sub_c;
    end else begin
      vcache_row_sub = north_vcache_sub_c;
    end
  end

  // x from the column field, prefixed with the requester pod
  assign x_cord_o = {pod_x_i, vcache_col};

  // y is one of the two vcache rows of the same pod
  assign y_cord_o = {pod_y_i, vcache_row_sub};

  // word address inside the vcache
  // block base plus offset, upper block bits fall off the epa
  assign epa_o = epa_width_c'(blk_idx * vcache_block_words_c + word_in_blk);

endmodule

//--- hw/direct_addr_map.sv
// direct address mapper
// global eva: coordinates and word address coded in the eva
// tile-group eva: tile offset added to the tile-group origin,
// kept inside the pod and the dmem window

module direct_addr_map (
  input  logic [eva_npa_pkg::eva_width_c-1:0]      eva_i,
  input  logic [eva_npa_pkg::x_sub_width_c-1:0]    tgo_x_i,
  input  logic [eva_npa_pkg::y_sub_width_c-1:0]    tgo_y_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_x_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_y_i,
  output logic [eva_npa_pkg::x_cord_width_c-1:0]   glb_x_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0]   glb_y_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]      glb_epa_o,
  output logic [eva_npa_pkg::x_cord_width_c-1:0]   tg_x_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0]   tg_y_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]      tg_epa_o
);

  import eva_npa_pkg::*;

  localparam int tg_x_w_lp = tg_x_msb_c - tg_x_lsb_c + 1;
  localparam int tg_y_w_lp = tg_y_msb_c - tg_y_lsb_c + 1;

  // tile offset inside the group
  logic [tg_x_w_lp-1:0]     tg_x_off;
  logic [tg_y_w_lp-1:0]     tg_y_off;
  // subcords after adding the origin
  logic [x_sub_width_c-1:0] tg_x_sub;
  logic [y_sub_width_c-1:0] tg_y_sub;

  // global class
  // 6-bit fields widen to full coordinates
  assign glb_x_o   = x_cord_width_c'(eva_i[glb_x_msb_c:glb_x_lsb_c]);
  assign glb_y_o   = y_cord_width_c'(eva_i[glb_y_msb_c:glb_y_lsb_c]);
  // byte offset to word address
  assign glb_epa_o = eva_i[glb_word_msb_c:glb_word_lsb_c];

  // tile-group class
  assign tg_x_off = eva_i[tg_x_msb_c:tg_x_lsb_c];
  assign tg_y_off = eva_i[tg_y_msb_c:tg_y_lsb_c];

  // wraps around the pod width
  assign tg_x_sub = x_sub_width_c'((tgo_x_i + tg_x_off) % num_tiles_x_c);

  // wraps around the tile rows, then skips the north vcache row
  assign tg_y_sub = y_sub_width_c'(1 + ((tgo_y_i + tg_y_off) % num_tiles_y_c));

  // group never leaves the requester pod
  assign tg_x_o = {pod_x_i, tg_x_sub};
  assign tg_y_o = {pod_y_i, tg_y_sub};

  // only the dmem window is reachable
  assign tg_epa_o = eva_i[tg_word_msb_c:tg_word_lsb_c] & tg_epa_mask_c;

endmodule

//--- hw/npa_select.sv
// npa selector
// decodes the address class from the top eva bits and picks
// the dram or direct mapper result, zeros for an invalid eva

module npa_select (
  input  logic [eva_npa_pkg::eva_width_c-1:0]    eva_i,
  input  logic [eva_npa_pkg::x_cord_width_c-1:0] dram_x_i,
  input  logic [eva_npa_pkg::y_cord_width_c-1:0] dram_y_i,
  input  logic [eva_npa_pkg::epa_width_c-1:0]    dram_epa_i,
  input  logic [eva_npa_pkg::x_cord_width_c-1:0] glb_x_i,
  input  logic [eva_npa_pkg::y_cord_width_c-1:0] glb_y_i,
  input  logic [eva_npa_pkg::epa_width_c-1:0]    glb_epa_i,
  input  logic [eva_npa_pkg::x_cord_width_c-1:0] tg_x_i,
  input  logic [eva_npa_pkg::y_cord_width_c-1:0] tg_y_i,
  input  logic [eva_npa_pkg::epa_width_c-1:0]    tg_epa_i,
  output logic [eva_npa_pkg::x_cord_width_c-1:0] x_cord_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0] y_cord_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]    epa_o,
  output eva_npa_pkg::addr_kind_e                kind_o
);

  import eva_npa_pkg::*;

  // raw tag matches
  logic is_dram;
  logic is_glb;
  logic is_tg;
  logic is_inv;

  assign is_dram = eva_i[dram_tag_bit_c];
  assign is_glb  = (eva_i[eva_width_c-1 -: 2] == glb_tag_c);
  assign is_tg   = (eva_i[eva_width_c-1 -: 3] == tg_tag_c);
  assign is_inv  = (eva_i[eva_width_c-1 -: 3] == inv_tag_c);

  // priority mux, dram first
  always_comb begin
    x_cord_o = '0;
    y_cord_o = '0;
    epa_o    = '0;
    kind_o   = ADDR_INVALID;
    if (is_dram) begin
      x_cord_o = dram_x_i;
      y_cord_o = dram_y_i;
      epa_o    = dram_epa_i;
      kind_o   = ADDR_DRAM;
    end else if (is_glb) begin
      x_cord_o = glb_x_i;
      y_cord_o = glb_y_i;
      epa_o    = glb_epa_i;
      kind_o   = ADDR_GLOBAL;
    end else if (is_tg) begin
      x_cord_o = tg_x_i;
      y_cord_o = tg_y_i;
      epa_o    = tg_epa_i;
      kind_o   = ADDR_TILE_GROUP;
    end
  end

  // the package tags must split the eva space into disjoint classes
  always_comb begin
    if (!$isunknown(eva_i)) begin
      assert ($onehot({is_dram, is_glb, is_tg, is_inv}))
        else $error("eva class decode not one-hot for %h", eva_i);
    end
  end

endmodule

//--- hw/eva_xlate_port.sv
// translator request port
// four-phase req/ack controller around the combinational mappers
// registers the eva and its context on request, then the npa
// one edge later, and holds it until the request drops

module eva_xlate_port (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     req_i,
  input  logic [eva_npa_pkg::eva_width_c-1:0]      eva_i,
  input  logic [eva_npa_pkg::x_sub_width_c-1:0]    tgo_x_i,
  input  logic [eva_npa_pkg::y_sub_width_c-1:0]    tgo_y_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_x_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_y_i,
  input  logic [eva_npa_pkg::x_cord_width_c-1:0]   x_in_i,
  input  logic [eva_npa_pkg::y_cord_width_c-1:0]   y_in_i,
  input  logic [eva_npa_pkg::epa_width_c-1:0]      epa_in_i,
  input  eva_npa_pkg::addr_kind_e                  kind_in_i,
  output logic                                     ack_o,
  output logic [eva_npa_pkg::eva_width_c-1:0]      eva_q_o,
  output logic [eva_npa_pkg::x_sub_width_c-1:0]    tgo_x_q_o,
  output logic [eva_npa_pkg::y_sub_width_c-1:0]    tgo_y_q_o,
  output logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_x_q_o,
  output logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_y_q_o,
  output logic [eva_npa_pkg::x_cord_width_c-1:0]   x_cord_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0]   y_cord_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]      epa_o,
  output eva_npa_pkg::addr_kind_e                  kind_o,
  output logic                                     invalid_o
);

  import eva_npa_pkg::*;

  // idle: waiting for req, busy: mappers settling, hold: ack up
  typedef enum logic [1:0] {
    IDLE = 2'd0,
    BUSY = 2'd1,
    HOLD = 2'd2
  } state_e;

  state_e state_q;

  // fsm and ack
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
      ack_o   <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (req_i) begin
            state_q <= BUSY;
          end
        end
        BUSY: begin
          state_q <= HOLD;
          ack_o   <= 1'b1;
        end
        HOLD: begin
          // release phase
          if (!req_i) begin
            state_q <= IDLE;
            ack_o   <= 1'b0;
          end
        end
        default: begin
          state_q <= IDLE;
          ack_o   <= 1'b0;
        end
      endcase
    end
  end

  // request capture
  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && req_i) begin
      eva_q_o   <= eva_i;
      tgo_x_q_o <= tgo_x_i;
      tgo_y_q_o <= tgo_y_i;
      pod_x_q_o <= pod_x_i;
      pod_y_q_o <= pod_y_i;
    end
  end

  // result registers, loaded once per exchange
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      x_cord_o  <= '0;
      y_cord_o  <= '0;
      epa_o     <= '0;
      kind_o    <= ADDR_INVALID;
      invalid_o <= 1'b0;
    end else if (state_q == BUSY) begin
      x_cord_o  <= x_in_i;
      y_cord_o  <= y_in_i;
      epa_o     <= epa_in_i;
      kind_o    <= kind_in_i;
      invalid_o <= (kind_in_i == ADDR_INVALID);
    end
  end

  // requester must keep req up until ack arrives
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $rose(ack_o) |-> $past(req_i))
    else $error("ack rose without an active request");

  // npa stays put for the whole ack phase
  assert property (@(posedge clk_i) disable iff (!arst_n_i)
    (ack_o && $past(ack_o)) |-> $stable({x_cord_o, y_cord_o, epa_o, kind_o, invalid_o}))
    else $error("npa changed while ack was high");

endmodule

//--- hw/eva_xlate_top.sv
// eva to npa translator
// request port in front of the dram hash and the direct mapper,
// which run side by side and are merged by the selector

module eva_xlate_top (
  input  logic                                     clk_i,
  input  logic                                     arst_n_i,
  input  logic                                     req_i,
  input  logic [eva_npa_pkg::eva_width_c-1:0]      eva_i,
  input  logic [eva_npa_pkg::x_sub_width_c-1:0]    tgo_x_i,
  input  logic [eva_npa_pkg::y_sub_width_c-1:0]    tgo_y_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_x_i,
  input  logic [eva_npa_pkg::pod_cord_width_c-1:0] pod_y_i,
  output logic                                     ack_o,
  output logic [eva_npa_pkg::x_cord_width_c-1:0]   x_cord_o,
  output logic [eva_npa_pkg::y_cord_width_c-1:0]   y_cord_o,
  output logic [eva_npa_pkg::epa_width_c-1:0]      epa_o,
  output eva_npa_pkg::addr_kind_e                  kind_o,
  output logic                                     invalid_o
);

  import eva_npa_pkg::*;

  // registered request
  logic [eva_width_c-1:0]      eva_q;
  logic [x_sub_width_c-1:0]    tgo_x_q;
  logic [y_sub_width_c-1:0]    tgo_y_q;
  logic [pod_cord_width_c-1:0] pod_x_q;
  logic [pod_cord_width_c-1:0] pod_y_q;

  // mapper results
  logic [x_cord_width_c-1:0] dram_x;
  logic [y_cord_width_c-1:0] dram_y;
  logic [epa_width_c-1:0]    dram_epa;
  logic [x_cord_width_c-1:0] glb_x;
  logic [y_cord_width_c-1:0] glb_y;
  logic [epa_width_c-1:0]    glb_epa;
  logic [x_cord_width_c-1:0] tg_x;
  logic [y_cord_width_c-1:0] tg_y;
  logic [epa_width_c-1:0]    tg_epa;

  // selected npa, back into the port
  logic [x_cord_width_c-1:0] sel_x;
  logic [y_cord_width_c-1:0] sel_y;
  logic [epa_width_c-1:0]    sel_epa;
  addr_kind_e                sel_kind;

  eva_xlate_port u_port (
    .clk_i(clk_i), .arst_n_i(arst_n_i), .req_i(req_i),
    .eva_i(eva_i), .tgo_x_i(tgo_x_i), .tgo_y_i(tgo_y_i),
    .pod_x_i(pod_x_i), .pod_y_i(pod_y_i),
    .x_in_i(sel_x), .y_in_i(sel_y), .epa_in_i(sel_epa), .kind_in_i(sel_kind),
    .ack_o(ack_o), .eva_q_o(eva_q), .tgo_x_q_o(tgo_x_q), .tgo_y_q_o(tgo_y_q),
    .pod_x_q_o(pod_x_q), .pod_y_q_o(pod_y_q),
    .x_cord_o(x_cord_o), .y_cord_o(y_cord_o), .epa_o(epa_o),
    .kind_o(kind_o), .invalid_o(invalid_o)
  );

  dram_hash u_dram_hash (
    .eva_i(eva_q), .pod_x_i(pod_x_q), .pod_y_i(pod_y_q),
    .x_cord_o(dram_x), .y_cord_o(dram_y), .epa_o(dram_epa)
  );

  direct_addr_map u_direct_map (
    .eva_i(eva_q), .tgo_x_i(tgo_x_q), .tgo_y_i(tgo_y_q),
    .pod_x_i(pod_x_q), .pod_y_i(pod_y_q),
    .glb_x_o(glb_x), .glb_y_o(glb_y), .glb_epa_o(glb_epa),
    .tg_x_o(tg_x), .tg_y_o(tg_y), .tg_epa_o(tg_epa)
  );

  npa_select u_select (
    .eva_i(eva_q),
    .dram_x_i(dram_x), .dram_y_i(dram_y), .dram_epa_i(dram_epa),
    .glb_x_i(glb_x), .glb_y_i(glb_y), .glb_epa_i(glb_epa),
    .tg_x_i(tg_x), .tg_y_i(tg_y), .tg_epa_i(tg_epa),
    .x_cord_o(sel_x), .y_cord_o(sel_y), .epa_o(sel_epa), .kind_o(sel_kind)
  );

endmodule

//--- testbench/eva_xlate_tb.sv
// testbench for the eva to npa translator
// walks a table of directed and random evas through the
// four-phase port and checks npa, class and ack timing

module eva_xlate_tb;

  import eva_npa_pkg::*;

  // one table row, stimulus then expected npa
  typedef struct packed {
    logic [eva_width_c-1:0]      eva;
    logic [x_sub_width_c-1:0]    tgo_x;
    logic [y_sub_width_c-1:0]    tgo_y;
    logic [pod_cord_width_c-1:0] pod_x;
    logic [pod_cord_width_c-1:0] pod_y;
    addr_kind_e                  kind;
    logic [x_cord_width_c-1:0]   x;
    logic [y_cord_width_c-1:0]   y;
    logic [epa_width_c-1:0]      epa;
    logic                        invalid;
  } row_t;

  logic                        clk;
  logic                        arst_n_i;
  logic                        req_i;
  logic [eva_width_c-1:0]      eva_i;
  logic [x_sub_width_c-1:0]    tgo_x_i;
  logic [y_sub_width_c-1:0]    tgo_y_i;
  logic [pod_cord_width_c-1:0] pod_x_i;
  logic [pod_cord_width_c-1:0] pod_y_i;
  logic                        ack_o;
  logic [x_cord_width_c-1:0]   x_cord_o;
  logic [y_cord_width_c-1:0]   y_cord_o;
  logic [epa_width_c-1:0]      epa_o;
  addr_kind_e                  kind_o;
  logic                        invalid_o;

  row_t   rows[$];
  integer seed = 87;
  int     cycles = 0;
  int     cycle_limit = 0;

  eva_xlate_top uut (
    .clk_i(clk), .arst_n_i(arst_n_i), .req_i(req_i),
    .eva_i(eva_i), .tgo_x_i(tgo_x_i), .tgo_y_i(tgo_y_i),
    .pod_x_i(pod_x_i), .pod_y_i(pod_y_i),
    .ack_o(ack_o), .x_cord_o(x_cord_o), .y_cord_o(y_cord_o),
    .epa_o(epa_o), .kind_o(kind_o), .invalid_o(invalid_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // run length guard, limit set once the table is built
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: translator stalled, run passed %0d cycles", cycle_limit);
      $display("sim failed");
      $fatal(1);
    end
  end

  // expected npa worked out from the address map
  function automatic row_t model_npa(input row_t r);
    row_t       m;
    logic [3:0] xsub;
    logic [2:0] ysum;
    m         = r;
    m.kind    = ADDR_INVALID;
    m.x       = '0;
    m.y       = '0;
    m.epa     = '0;
    m.invalid = 1'b0;
    if (r.eva[31]) begin
      m.kind = ADDR_DRAM;
      m.x    = {r.pod_x, r.eva[8:5]};
      m.y    = {r.pod_y, (r.eva[9] ? 4'd9 : 4'd0)};
      // block index times 8 words, low 13 block bits survive
      m.epa  = {r.eva[22:10], r.eva[4:2]};
    end else if (r.eva[31:30] == 2'b01) begin
      m.kind = ADDR_GLOBAL;
      m.x    = {1'b0, r.eva[23:18]};
      m.y    = {1'b0, r.eva[29:24]};
      m.epa  = r.eva[17:2];
    end else if (r.eva[31:29] == 3'b001) begin
      m.kind = ADDR_TILE_GROUP;
      // 4-bit and 3-bit sums wrap at the pod size
      xsub   = r.tgo_x + r.eva[24:21];
      ysum   = r.tgo_y[2:0] + r.eva[27:25];
      m.x    = {r.pod_x, xsub};
      m.y    = {r.pod_y, 4'(ysum) + 4'd1};
      m.epa  = {6'b0, r.eva[11:2]};
    end else begin
      m.invalid = 1'b1;
    end
    return m;
  endfunction

  task automatic add_row(input logic [31:0] eva, input logic [3:0] tx, input logic [3:0] ty,
                         input logic [2:0] px, input logic [2:0] py);
    row_t r;
    r       = '0;
    r.eva   = eva;
    r.tgo_x = tx;
    r.tgo_y = ty;
    r.pod_x = px;
    r.pod_y = py;
    rows.push_back(model_npa(r));
  endtask

  task automatic check_kind(input string name, input addr_kind_e act, input addr_kind_e exp);
    if (act !== exp) begin
      $display("error at %0t: %s is %s, expected %s", $time, name, act.name(), exp.name());
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_cord(input string name, input logic [x_cord_width_c-1:0] act,
                            input logic [x_cord_width_c-1:0] exp);
    if (act !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_epa(input string name, input logic [epa_width_c-1:0] act,
                           input logic [epa_width_c-1:0] exp);
    if (act !== exp) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("error at %0t: %s is %b, expected %b", $time, name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic check_count(input string name, input int act, input int exp);
    if (act != exp) begin
      $display("error at %0t: %s is %0d, expected %0d", $time, name, act, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic compare_npa(input row_t r);
    check_kind("kind_o", kind_o, r.kind);
    check_cord("x_cord_o", x_cord_o, r.x);
    check_cord("y_cord_o", y_cord_o, r.y);
    check_epa("epa_o", epa_o, r.epa);
    check_bit("invalid_o", invalid_o, r.invalid);
  endtask

  initial begin : main
    int   edges;
    int   extra;
    row_t r;
    arst_n_i = 1'b0;
    req_i    = 1'b0;
    eva_i    = '0;
    tgo_x_i  = '0;
    tgo_y_i  = '0;
    pod_x_i  = '0;
    pod_y_i  = '0;

    // dram: both rows, column wrap into the next block, epa truncation
    add_row(32'h8000_0000, 4'd0, 4'd0, 3'd0, 3'd0);
    add_row(32'h8000_01E4, 4'd0, 4'd0, 3'd2, 3'd1);
    add_row(32'h8000_03E0, 4'd0, 4'd0, 3'd5, 3'd6);
    add_row(32'h8000_0400, 4'd0, 4'd0, 3'd5, 3'd6);
    add_row(32'h8000_03FC, 4'd3, 4'd2, 3'd7, 3'd7);
    add_row(32'hFFFF_FFFC, 4'd0, 4'd0, 3'd1, 3'd4);
    // global, pod ignored
    add_row(32'h4000_0000, 4'd5, 4'd5, 3'd3, 3'd3);
    add_row(32'h7FFF_FFFC, 4'd0, 4'd0, 3'd2, 3'd2);
    add_row(32'h4A3C_1238, 4'd1, 4'd1, 3'd0, 3'd0);
    // tile group, origin wrap and dmem mask
    add_row(32'h2000_0000, 4'd0, 4'd0, 3'd1, 3'd2);
    add_row(32'h3FE0_0FFC, 4'd15, 4'd7, 3'd6, 3'd3);
    add_row(32'h2123_4567, 4'd9, 4'd3, 3'd4, 3'd5);
    // top bits 000
    add_row(32'h0000_0000, 4'd0, 4'd0, 3'd0, 3'd0);
    add_row(32'h1FFF_FFFC, 4'd2, 4'd6, 3'd7, 3'd1);
    repeat (14) begin
      add_row($random(seed), 4'($random(seed)), 4'($random(seed)),
              3'($random(seed)), 3'($random(seed)));
    end
    cycle_limit = rows.size() * 8 + 50;

    repeat (10) @(negedge clk);
    arst_n_i = 1'b1;
    // reset state
    check_bit("ack_o", ack_o, 1'b0);
    check_cord("x_cord_o", x_cord_o, '0);
    check_cord("y_cord_o", y_cord_o, '0);
    check_epa("epa_o", epa_o, '0);
    check_kind("kind_o", kind_o, ADDR_INVALID);
    check_bit("invalid_o", invalid_o, 1'b0);

    foreach (rows[i]) begin
      r       = rows[i];
      eva_i   = r.eva;
      tgo_x_i = r.tgo_x;
      tgo_y_i = r.tgo_y;
      pod_x_i = r.pod_x;
      pod_y_i = r.pod_y;
      req_i   = 1'b1;
      // each falling edge follows one rising edge
      edges = 0;
      while (!ack_o) begin
        @(negedge clk);
        edges++;
      end
      check_count("ack_o latency in edges", edges, 2);
      compare_npa(r);
      // requester stalls with req held high
      extra = $unsigned($random(seed)) % 4;
      repeat (extra) begin
        @(negedge clk);
        check_bit("ack_o", ack_o, 1'b1);
        compare_npa(r);
      end
      req_i = 1'b0;
      @(negedge clk);
      check_bit("ack_o", ack_o, 1'b0);
    end

    $display("sim passed");
    $finish;
  end

endmodule

//--- build.f
hw/eva_npa_pkg.sv
hw/dram_hash.sv
hw/direct_addr_map.sv
hw/npa_select.sv
hw/eva_xlate_port.sv
hw/eva_xlate_top.sv
testbench/eva_xlate_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the eva translator testbench with verilator, run it, keep the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module eva_xlate_tb -o eva_xlate_sim \
  || { echo "verilator build error"; exit 1; }

./obj_dir/eva_xlate_sim > sim.log 2>&1
cat sim.log

# the log decides the outcome
grep -q "sim failed" sim.log && exit 1
grep -q "sim passed" sim.log || exit 1
exit 0
